// File: hw/pixel_colorizer.sv
`include "video_defs.svh"

module pixel_colorizer
    import video_pkg::*;
(
    input  logic    bdiv,
    input  logic    rst_n,
    input  coord_t  x,
    input  coord_t  y,
    input  logic    hs_raw,
    input  logic    vs_raw,
    input  logic    visible,
    input  logic    pix_bit,
    input  attr_t   cur_attr,
    input  border_t border,
    output red_t    r,
    output green_t  g,
    output blue_t   b,
    output logic    hs,
    output logic    vs
);

    // --------------------
    // Stage 1 position
    // --------------------

    // Delayed beam to match the fetched pixel
    coord_t x_d;
    coord_t y_d;

    always_ff @(posedge bdiv) begin
        x_d <= x;
        y_d <= y;
    end

    logic in_window;

    assign in_window = (x_d >= coord_t'(`WIN_X0)) && (x_d < coord_t'(`WIN_X1)) &&
                       (y_d >= coord_t'(`WIN_Y0)) && (y_d < coord_t'(`WIN_Y1));

    // --------------------
    // Cell colour
    // --------------------

    // Ink for a set bit, paper otherwise
    logic [2:0] colour;
    logic       bright;

    red_t   cell_r;
    green_t cell_g;
    blue_t  cell_b;

    assign colour = pix_bit ? cur_attr[2:0] : cur_attr[5:3];
    assign bright = cur_attr[6];

    // Colour bit 0 blue, bit 1 red, bit 2 green
    assign cell_r = colour[1] ? (bright ? `LEVEL_FULL_R : `LEVEL_HALF_R) : '0;
    assign cell_g = colour[2] ? (bright ? `LEVEL_FULL_G : `LEVEL_HALF_G) : '0;
    assign cell_b = colour[0] ? (bright ? `LEVEL_FULL_B : `LEVEL_HALF_B) : '0;

    // --------------------
    // Stage 2 output register
    // --------------------

    always_ff @(posedge bdiv) begin
        if (!rst_n) begin
            r  <= '0;
            g  <= '0;
            b  <= '0;
            hs <= 1'b0;
            vs <= 1'b0;
        end else begin
            hs <= hs_raw;
            vs <= vs_raw;
            if (!visible) begin
                // Blanking
                r <= '0;
                g <= '0;
                b <= '0;
            end else if (!in_window) begin
                // Border is always half level
                r <= border[0] ? `LEVEL_HALF_R : '0;
                g <= border[1] ? `LEVEL_HALF_G : '0;
                b <= border[2] ? `LEVEL_HALF_B : '0;
            end else begin
                r <= cell_r;
                g <= cell_g;
                b <= cell_b;
            end
        end
    end

endmodule

// File: hw/raster_timing.sv
`include "video_defs.svh"

module raster_timing
    import video_pkg::*;
(
    input  logic   bdiv,
    input  logic   rst_n,
    output coord_t x,
    output coord_t y,
    output logic   hs_raw,
    output logic   vs_raw,
    output logic   visible
);

    // Last position on a line and in a frame
    logic line_end;
    logic frame_end;

    assign line_end  = (x == coord_t'(`H_TOTAL - 1));
    assign frame_end = (y == coord_t'(`V_TOTAL - 1));

    // --------------------
    // Beam counters
    // --------------------

    // x runs every pixel
    // y steps once per line
    always_ff @(posedge bdiv) begin
        if (!rst_n) begin
            x <= '0;
            y <= '0;
        end else begin
            if (line_end) begin
                x <= '0;
                if (frame_end) begin
                    y <= '0;
                end else begin
                    y <= y + 1'b1;
                end
            end else begin
                x <= x + 1'b1;
            end
        end
    end

    // --------------------
    // Stage 1 flags
    // --------------------

    // Decoded from the current position
    // Valid one cycle later alongside the fetched pixel
    always_ff @(posedge bdiv) begin
        if (!rst_n) begin
            hs_raw  <= 1'b0;
            vs_raw  <= 1'b0;
            visible <= 1'b0;
        end else begin
            // Inclusive sync ranges
            hs_raw  <= (x >= coord_t'(`H_SYNC_START)) && (x <= coord_t'(`H_SYNC_END));
            vs_raw  <= (y >= coord_t'(`V_SYNC_START)) && (y <= coord_t'(`V_SYNC_END));
            // Active 640x480 area
            visible <= (x < coord_t'(`H_VISIBLE)) && (y < coord_t'(`V_VISIBLE));
        end
    end

endmodule

// File: hw/screen_fetch.sv
`include "video_defs.svh"

module screen_fetch
    import video_pkg::*;
(
    input  logic       bdiv,
    input  logic       rst_n,
    input  coord_t     x,
    input  coord_t     y,
    input  vbyte_t     rd_data,
    output vram_addr_t rd_addr,
    output logic       pix_bit,
    output attr_t      cur_attr
);

    // --------------------
    // Cell addressing
    // --------------------

    // Position within a 16 pixel cell
    logic [3:0] phase;

    // Beam relative to the window
    // ahead_x looks one cell forward
    coord_t ahead_x;
    coord_t rel_y;

    // Bitmap row 0..191 and byte column 0..31
    logic [7:0] row;
    logic [4:0] col;

    vram_addr_t bmp_addr;
    vram_addr_t attr_addr;

    assign phase   = x[3:0];
    assign ahead_x = x + coord_t'(16) - coord_t'(`WIN_X0);
    assign rel_y   = y - coord_t'(`WIN_Y0);

    // Lines doubled vertically
    assign row = rel_y[8:1];
    // Each byte spans 16 pixels
    assign col = ahead_x[8:4];

    // row*32 + col
    assign bmp_addr  = {1'b0, row, col};
    // One attribute per 8 rows
    assign attr_addr = vram_addr_t'(`ATTR_BASE) + vram_addr_t'({row[7:3], col});

    // Phase 1 asks for the attribute
    // Every other phase points at the bitmap
    assign rd_addr = (phase == 4'd1) ? attr_addr : bmp_addr;

    // --------------------
    // Holding and shift registers
    // --------------------

    vbyte_t bmp_hold;
    attr_t  attr_hold;
    vbyte_t shift_reg;
    attr_t  attr_reg;

    always_ff @(posedge bdiv) begin
        // Bitmap byte from the phase 0 read
        if (phase == 4'd1) begin
            bmp_hold <= rd_data;
        end
        // Attribute byte from the phase 1 read
        if (phase == 4'd2) begin
            attr_hold <= rd_data;
        end
        // Cell boundary
        if (phase == 4'd15) begin
            shift_reg <= bmp_hold;
            attr_reg  <= attr_hold;
        end else if (phase[0]) begin
            // MSB first, two pixels per bit
            shift_reg <= {shift_reg[6:0], 1'b0};
        end
    end

    // --------------------
    // Stage 1 outputs
    // --------------------

    // Lines up with the registered sync flags
    always_ff @(posedge bdiv) begin
        if (!rst_n) begin
            pix_bit  <= 1'b0;
            cur_attr <= '0;
        end else begin
            pix_bit  <= shift_reg[7];
            cur_attr <= attr_reg;
        end
    end

endmodule

// File: hw/video_defs.svh
`ifndef VIDEO_DEFS_SVH
`define VIDEO_DEFS_SVH

// --------------------
// Horizontal timing in pixels
// --------------------
`define H_VISIBLE    640
`define H_SYNC_START 656
`define H_SYNC_END   751
`define H_TOTAL      800

// --------------------
// Vertical timing in lines
// --------------------
`define V_VISIBLE    480
`define V_SYNC_START 490
`define V_SYNC_END   491
`define V_TOTAL      525

// Paper window of 512x384 inside the border
// Left edge must stay a multiple of 16 for the cell phase
`define WIN_X0 64
`define WIN_X1 576
`define WIN_Y0 48
`define WIN_Y1 432

// Attribute area follows the 6 KiB bitmap
`define ATTR_BASE 6144

// Component levels for 5-6-5 output
`define LEVEL_HALF_R 5'h0F
`define LEVEL_HALF_G 6'h1F
`define LEVEL_HALF_B 5'h0F
`define LEVEL_FULL_R 5'h1F
`define LEVEL_FULL_G 6'h3F
`define LEVEL_FULL_B 5'h1F

`endif

// File: hw/video_pkg.sv
package video_pkg;

    // --------------------
    // Raster position
    // --------------------

    // Beam x or y, covers 0 to 799
    typedef logic [9:0] coord_t;

    // --------------------
    // Video memory
    // --------------------

    // 16 KiB byte address
    typedef logic [13:0] vram_addr_t;

    // Raw memory byte
    typedef logic [7:0] vbyte_t;

    // Cell attribute
    // Bits 2..0 ink, bits 5..3 paper, bit 6 bright
    typedef logic [7:0] attr_t;

    // --------------------
    // Colour output
    // --------------------
    typedef logic [4:0] red_t;
    typedef logic [5:0] green_t;
    typedef logic [4:0] blue_t;

    // Border colour, bit 0 red, bit 1 green, bit 2 blue
    typedef logic [2:0] border_t;

endpackage

// File: hw/video_ram.sv
module video_ram
    import video_pkg::*;
(
    input  logic       bdiv,
    // CPU side
    input  logic       wr_en,
    input  vram_addr_t wr_addr,
    input  vbyte_t     wr_data,
    // Video side
    input  vram_addr_t rd_addr,
    output vbyte_t     rd_data
);

    // One byte per address
    localparam int DEPTH = 1 << $bits(vram_addr_t);

    // --------------------
    // Storage
    // --------------------

    // Bitmap at 0, attributes at ATTR_BASE
    vbyte_t mem [0:DEPTH-1];

    // CPU write port
    // One byte per strobe, no handshake
    always_ff @(posedge bdiv) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // --------------------
    // Video read port
    // --------------------

    // Registered read
    // Data arrives the cycle after the address
    always_ff @(posedge bdiv) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// File: hw/video_top.sv
module video_top
    import video_pkg::*;
(
    input  logic       bdiv,
    input  logic       rst_n,
    // CPU write port
    input  logic       wr_en,
    input  vram_addr_t wr_addr,
    input  vbyte_t     wr_data,
    // Border colour
    input  border_t    border,
    // Video out
    output red_t       r,
    output green_t     g,
    output blue_t      b,
    output logic       hs,
    output logic       vs
);

    // --------------------
    // Internal nets
    // --------------------

    // Beam position at stage 0
    coord_t x;
    coord_t y;

    // Stage 1 flags
    logic hs_raw;
    logic vs_raw;
    logic visible;

    // Fetch to memory
    vram_addr_t rd_addr;
    vbyte_t     rd_data;

    // Stage 1 pixel
    logic  pix_bit;
    attr_t cur_attr;

    // --------------------
    // Blocks
    // --------------------

    raster_timing u_timing (
        .bdiv    (bdiv),
        .rst_n   (rst_n),
        .x       (x),
        .y       (y),
        .hs_raw  (hs_raw),
        .vs_raw  (vs_raw),
        .visible (visible)
    );

    video_ram u_vram (
        .bdiv    (bdiv),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    screen_fetch u_fetch (
        .bdiv     (bdiv),
        .rst_n    (rst_n),
        .x        (x),
        .y        (y),
        .rd_data  (rd_data),
        .rd_addr  (rd_addr),
        .pix_bit  (pix_bit),
        .cur_attr (cur_attr)
    );

    pixel_colorizer u_color (
        .bdiv     (bdiv),
        .rst_n    (rst_n),
        .x        (x),
        .y        (y),
        .hs_raw   (hs_raw),
        .vs_raw   (vs_raw),
        .visible  (visible),
        .pix_bit  (pix_bit),
        .cur_attr (cur_attr),
        .border   (border),
        .r        (r),
        .g        (g),
        .b        (b),
        .hs       (hs),
        .vs       (vs)
    );

endmodule

// File: sources.f
+incdir+hw
hw/video_pkg.sv
hw/raster_timing.sv
hw/video_ram.sv
hw/screen_fetch.sv
hw/pixel_colorizer.sv
hw/video_top.sv
tests/tb_video_top.sv

// File: tests/tb_video_top.sv
`include "video_defs.svh"

module tb_video_top
    import video_pkg::*;
();

    localparam int CLK_PERIOD   = 4;
    localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;
    // Bitmap plus attributes
    localparam int SCREEN_BYTES = `ATTR_BASE + 768;
    // Last checked position, first blank line of frame 2
    localparam int END_POS      = 2 * FRAME_CYCLES + `V_VISIBLE * `H_TOTAL;
    localparam int WATCHDOG     = 3 * FRAME_CYCLES * CLK_PERIOD;

    logic       bdiv;
    logic       rst_n;
    logic       wr_en;
    vram_addr_t wr_addr;
    vbyte_t     wr_data;
    border_t    border;
    red_t       r;
    green_t     g;
    blue_t      b;
    logic       hs;
    logic       vs;

    // Copy of every byte written to video RAM
    vbyte_t shadow [0:SCREEN_BYTES-1];

    integer      seed;
    int          cyc;
    int          k;
    int          px;
    int          py;
    logic        check_rgb;
    logic        in_win;
    logic [17:0] exp_vec;
    int          full_seen;
    int          half_seen;

    video_top UUT (
        .bdiv    (bdiv),
        .rst_n   (rst_n),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .border  (border),
        .r       (r),
        .g       (g),
        .b       (b),
        .hs      (hs),
        .vs      (vs)
    );

    initial begin
        bdiv = 1'b0;
        forever #(CLK_PERIOD / 2) bdiv = ~bdiv;
    end

    // --------------------
    // Failure handling
    // --------------------

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        abort_run($sformatf("FAILED %s at pos %0d (x %0d, y %0d): got 0x%0h, expected 0x%0h",
                            name, k, px, py, got, want));
    endtask

    // --------------------
    // Reference model
    // --------------------

    // Packed as {r, g, b, hs, vs}
    function automatic logic [17:0] expected_pixel(input int ex, input int ey,
                                                   input border_t bcol);
        red_t       er;
        green_t     eg;
        blue_t      eb;
        int         cx;
        int         cy;
        int         bit_idx;
        vbyte_t     bmp;
        attr_t      attr;
        logic [2:0] colour;
        er = '0;
        eg = '0;
        eb = '0;
        if (ex < `H_VISIBLE && ey < `V_VISIBLE) begin
            if (ex < `WIN_X0 || ex >= `WIN_X1 || ey < `WIN_Y0 || ey >= `WIN_Y1) begin
                // Border at half level only
                if (bcol[0]) er = `LEVEL_HALF_R;
                if (bcol[1]) eg = `LEVEL_HALF_G;
                if (bcol[2]) eb = `LEVEL_HALF_B;
            end else begin
                cx = ex - `WIN_X0;
                cy = (ey - `WIN_Y0) / 2;
                // Byte per 16 pixels, MSB leftmost, each bit two pixels wide
                bmp     = shadow[cy * 32 + cx / 16];
                attr    = shadow[`ATTR_BASE + (cy / 8) * 32 + cx / 16];
                bit_idx = 7 - (cx % 16) / 2;
                colour  = bmp[bit_idx] ? attr[2:0] : attr[5:3];
                if (colour[1]) er = attr[6] ? `LEVEL_FULL_R : `LEVEL_HALF_R;
                if (colour[2]) eg = attr[6] ? `LEVEL_FULL_G : `LEVEL_HALF_G;
                if (colour[0]) eb = attr[6] ? `LEVEL_FULL_B : `LEVEL_HALF_B;
            end
        end
        return {er, eg, eb,
                ex >= `H_SYNC_START && ex <= `H_SYNC_END,
                ey >= `V_SYNC_START && ey <= `V_SYNC_END};
    endfunction

    // --------------------
    // Output compare
    // --------------------

    // Outputs read at a rising edge belong to position cyc-2
    always @(posedge bdiv) begin
        if (rst_n) begin
            k = cyc - 2;
            if (k < 0) begin
                // Still the reset values
                px        = -1;
                py        = -1;
                exp_vec   = '0;
                check_rgb = 1'b1;
            end else begin
                px        = k % `H_TOTAL;
                py        = (k / `H_TOTAL) % `V_TOTAL;
                exp_vec   = expected_pixel(px, py, border);
                // Frame 0 picture is written while shown
                check_rgb = (k >= FRAME_CYCLES) || px >= `H_VISIBLE || py >= `V_VISIBLE;
            end
            assert (hs === exp_vec[1]) else report_mismatch("hs", hs, exp_vec[1]);
            assert (vs === exp_vec[0]) else report_mismatch("vs", vs, exp_vec[0]);
            if (check_rgb) begin
                assert (r === exp_vec[17:13]) else report_mismatch("r", r, exp_vec[17:13]);
                assert (g === exp_vec[12:7]) else report_mismatch("g", g, exp_vec[12:7]);
                assert (b === exp_vec[6:2]) else report_mismatch("b", b, exp_vec[6:2]);
                in_win = px >= `WIN_X0 && px < `WIN_X1 && py >= `WIN_Y0 && py < `WIN_Y1;
                if (in_win && (exp_vec[17:13] == 5'h1F || exp_vec[12:7] == 6'h3F ||
                               exp_vec[6:2] == 5'h1F)) begin
                    full_seen++;
                end else if (in_win && exp_vec[17:2] != '0) begin
                    half_seen++;
                end
            end
            cyc = cyc + 1;
        end
    end

    // --------------------
    // Stimulus
    // --------------------

    task automatic write_byte(input int addr, input vbyte_t data);
        @(negedge bdiv);
        wr_en        = 1'b1;
        wr_addr      = vram_addr_t'(addr);
        wr_data      = data;
        shadow[addr] = data;
    endtask

    // Random bitmap and attributes, optionally forcing bright per cell parity
    task automatic fill_screen(input logic alternate_bright);
        integer rnd;
        vbyte_t data;
        for (int a = 0; a < SCREEN_BYTES; a++) begin
            rnd  = $random(seed);
            data = rnd[7:0];
            if (alternate_bright && a >= `ATTR_BASE) begin
                data[6] = a[0];
            end
            write_byte(a, data);
        end
        @(negedge bdiv);
        wr_en = 1'b0;
    endtask

    // Beam holds position cyc between rising edges
    task automatic wait_for_position(input int target);
        while (cyc < target) begin
            @(negedge bdiv);
        end
    endtask

    initial begin
        integer  rnd;
        border_t old_border;
        seed        = 32'h4e4cfaee;
        cyc         = 0;
        full_seen   = 0;
        half_seen   = 0;
        rst_n       = 1'b0;
        wr_en       = 1'b0;
        wr_addr     = '0;
        wr_data     = '0;
        border      = '0;
        repeat (2) @(negedge bdiv);
        rst_n = 1'b1;

        // Frame 0 loads the first picture
        fill_screen(1'b0);
        rnd    = $random(seed);
        border = rnd[2:0];

        // New picture and border during frame 1 vertical blanking
        wait_for_position(FRAME_CYCLES + (`V_VISIBLE + 1) * `H_TOTAL);
        fill_screen(1'b1);
        old_border = border;
        // New border differs from the old one and is not black
        while (border == old_border || border == '0) begin
            rnd    = $random(seed);
            border = rnd[2:0];
        end

        // Frame 2 visible area fully compared
        wait_for_position(END_POS + 3);
        assert (full_seen > 0) else abort_run("No bright pixel was seen in the window");
        assert (half_seen > 0) else abort_run("No half level pixel was seen in the window");
        $display("Done: no errors");
        $finish;
    end

    initial begin
        #(WATCHDOG);
        abort_run("Timeout: the run went past three frames without finishing");
    end

endmodule
